/* conv_engine.f */
+incdir+logic
logic/conv_pkg.sv
logic/count_if.sv
logic/conv_ctrl.sv
logic/frame_counter.sv
logic/weight_bank.sv
logic/line_window.sv
logic/conv_tree.sv
logic/conv_top.sv
dv/conv_checker.sv
dv/conv_tb.sv

/* dv/conv_checker.sv */
`timescale 1ns/1ns
`default_nettype none

`include "conv_defs.svh"

module conv_checker (
	input  logic             clk,
	input  logic             reset,
	input  logic             weight_valid,
	input  logic             conv_valid,
	input  conv_pkg::pixel_t conv_data,
	input  logic             weights_ready,
	input  logic             frame_done,
	input  logic             run_over,
	output int               mismatch_errors,
	output int               protocol_errors
);

	conv_pkg::pixel_t expect_q[$];
	conv_pkg::pixel_t expected;
	int               mismatches      = 0;
	int               faults          = 0;
	int               frames_expected = 0;
	int               frames_seen     = 0;
	int               frame_results   = 0;
	int               load_count;
	logic             ready_model;
	logic             last_valid      = 1'b0;
	logic             last_done       = 1'b0;
	logic             closed          = 1'b0;

	assign mismatch_errors = mismatches;
	assign protocol_errors = faults;

	initial
	begin : read_expected
		int               fd;
		int               code;
		logic [7:0]       tag;
		logic [15:0]      word;
		logic [8*120-1:0] rest;

		fd = $fopen("dv/conv_golden.txt", "r");
		if (fd != 0)
		begin
			code = $fscanf(fd, " %c", tag);
			while (code == 1)
			begin
				if (tag == "E")
				begin
					for (int k = 0; k < `CONV_IMG_WIDTH; k++)
					begin
						code = $fscanf(fd, " %h", word);
						expect_q.push_back(word);
					end
					frames_expected++;
				end
				else
					code = $fgets(rest, fd);
				code = $fscanf(fd, " %c", tag);
			end
			$fclose(fd);
		end
	end

	task automatic report_mismatch(input string name, input logic [15:0] exp_value,
		input logic [15:0] act_value);
		$display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name,
			exp_value, act_value);
		mismatches++;
	endtask

	task automatic report_fault(input string msg);
		$display("error at %0t ns: %s", $time, msg);
		faults++;
	endtask

	// weights_ready rises with the 25th weight of a load and drops with the next one.
	always @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			load_count  <= 0;
			ready_model <= 1'b0;
		end
		else if (weight_valid)
		begin
			load_count  <= (load_count == `CONV_TAPS) ? 1 : load_count + 1;
			ready_model <= (load_count == `CONV_TAPS - 1);
		end
	end

	//----------------------------------------------------------------------
	// mid-cycle comparison
	//----------------------------------------------------------------------
	always @(negedge clk)
	begin
		if (reset)
		begin
			last_valid = 1'b0;
			last_done  = 1'b0;
		end
		else
		begin
			if (weights_ready !== ready_model)
				report_mismatch("weights_ready", 16'(ready_model), 16'(weights_ready));
			if (conv_valid === 1'b1)
			begin
				frame_results++;
				if (frame_results > `CONV_IMG_WIDTH)
					report_fault("more than eight results in one frame");
				if (expect_q.size() == 0)
					report_fault("conv_valid with no expected result left");
				else
				begin
					expected = expect_q.pop_front();
					if (conv_data !== expected)
						report_mismatch("conv_data", expected, conv_data);
				end
			end
			if (frame_done === 1'b1)
			begin
				if (last_done)
					report_fault("frame_done stayed high for more than one cycle");
				else if (!last_valid || conv_valid === 1'b1 ||
					frame_results != `CONV_IMG_WIDTH)
					report_fault("frame_done did not follow the eighth result of a frame");
				frames_seen++;
				frame_results = 0;
			end
			last_valid = (conv_valid === 1'b1);
			last_done  = (frame_done === 1'b1);
		end

		if (run_over && !closed)
		begin
			closed = 1'b1;
			if (expect_q.size() != 0)
				report_fault($sformatf("%0d expected results never appeared", expect_q.size()));
			if (frames_seen != frames_expected)
				report_fault($sformatf("saw %0d frame_done pulses for %0d frames",
					frames_seen, frames_expected));
		end
	end

endmodule

`default_nettype wire

/* dv/conv_golden.txt */
# tags: W five weights, P one row of eight pixels, X four stray pixels, E eight results
# all values are 16-bit hex, two's complement; weights go in raster order of the kernel
# frame 1, first weight set, strays while loading and while draining
W 0003 FFFF 0002 0000 0005
X 7FFF 8000 1234 ABCD
W FFFC 0007 0001 FFFE 0006
W 0001 0000 FFFD 0008 0002
W 0009 FFFB 0004 0001 FFFF
W 0002 0003 FFFA 0000 0014
P 2000 2007 200E 2015 201C 2023 202A 2031
P 2064 206B 2072 2079 2080 2087 208E 2095
P 20C8 20CF 20D6 20DD 20E4 20EB 20F2 20F9
P 212C 2133 213A 2141 2148 214F 2156 215D
P 2190 2197 219E 21A5 21AC 21B3 21BA 21C1
P 21F4 21FB 2202 2209 2210 2217 221E 2225
X 7FFF 8000 1234 ABCD
E B483 B5EF B75B B8C7 C8D3 CA3F CBAB CD17
# frame 2, same weights
P 7000 7111 7222 7333 7444 7555 7666 7777
P 6D00 6E11 6F22 7033 7144 7255 7366 7477
P 6A00 6B11 6C22 6D33 6E44 6F55 7066 7177
P 6700 6811 6922 6A33 6B44 6C55 6D66 6E77
P 6400 6511 6622 6733 6844 6955 6A66 6B77
P 6100 6211 6322 6433 6544 6655 6766 6877
X 0F0F F0F0 5555 AAAA
E EAE5 2259 59CD 9141 4EE5 8659 BDCD F541
# frame 3, second weight set loaded after frame 2
W FF9C 0032 0000 0019 FFF9
X 4321 FEDC 0BAD 7777
W 000C FED4 03E8 0003 0000
W 0000 0004 FFF8 0010 FFE0
W 0040 0000 FFFF 0002 01F4
W F830 000B 0000 0006 0001
P FFF0 FFF3 FFF6 FFF9 FFFC FFFF 0002 0005
P 0030 0033 0036 0039 003C 003F 0042 0045
P 0070 0073 0076 0079 007C 007F 0082 0085
P 00B0 00B3 00B6 00B9 00BC 00BF 00C2 00C5
P 00F0 00F3 00F6 00F9 00FC 00FF 0102 0105
P 0130 0133 0136 0139 013C 013F 0142 0145
X 7FFF 8000 1234 ABCD
E ED95 E4BF DBE9 D313 3115 283F 1F69 1693

/* dv/conv_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "conv_defs.svh"

module conv_tb;

	localparam int CLK_PERIOD  = 4;
	localparam int FRAMES      = 3;
	localparam int STRAY_COUNT = 4;
	localparam int FRAME_PIX   = `CONV_IMG_WIDTH * `CONV_IMG_HEIGHT;
	// pixels, weights and 20 spare cycles per frame, plus a little for reset.
	localparam int TIMEOUT_NS  = (FRAMES * (FRAME_PIX + `CONV_TAPS + 20) + 10) * CLK_PERIOD;

	logic             clk;
	logic             reset;
	logic             weight_valid;
	conv_pkg::pixel_t weight_data;
	logic             pixel_valid;
	conv_pkg::pixel_t pixel_data;
	logic             conv_valid;
	conv_pkg::pixel_t conv_data;
	logic             weights_ready;
	logic             frame_done;
	logic             run_over;
	int               mismatch_errors;
	int               protocol_errors;

	conv_top dut (
		.clk           (clk),
		.reset         (reset),
		.weight_valid  (weight_valid),
		.weight_data   (weight_data),
		.pixel_valid   (pixel_valid),
		.pixel_data    (pixel_data),
		.conv_valid    (conv_valid),
		.conv_data     (conv_data),
		.weights_ready (weights_ready),
		.frame_done    (frame_done)
	);

	conv_checker chk (
		.clk             (clk),
		.reset           (reset),
		.weight_valid    (weight_valid),
		.conv_valid      (conv_valid),
		.conv_data       (conv_data),
		.weights_ready   (weights_ready),
		.frame_done      (frame_done),
		.run_over        (run_over),
		.mismatch_errors (mismatch_errors),
		.protocol_errors (protocol_errors)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#(CLK_PERIOD / 2) clk = ~clk;
	end

	//----------------------------------------------------------------------
	// drive helpers
	//----------------------------------------------------------------------
	task automatic step();
		@(posedge clk);
		#1; // inputs change just after the edge.
	endtask

	task automatic send_weight(input conv_pkg::pixel_t value);
		weight_valid = 1'b1;
		weight_data  = value;
		step();
		weight_valid = 1'b0;
	endtask

	task automatic send_pixel(input conv_pkg::pixel_t value);
		pixel_valid = 1'b1;
		pixel_data  = value;
		step();
		pixel_valid = 1'b0;
	endtask

	task automatic wait_frame_done();
		while (frame_done !== 1'b1)
			step();
	endtask

	initial
	begin
		#(TIMEOUT_NS);
		$display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
		$display(">>> FAIL");
		$finish;
	end

	//----------------------------------------------------------------------
	// golden file stimulus
	//----------------------------------------------------------------------
	initial
	begin
		int               fd;
		int               code;
		int               pixels_sent;
		logic             frame_pending;
		logic [7:0]       tag;
		logic [15:0]      word;
		logic [8*120-1:0] rest;

		weight_valid = 1'b0;
		weight_data  = '0;
		pixel_valid  = 1'b0;
		pixel_data   = '0;
		run_over     = 1'b0;
		reset        = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		repeat (4) step(); // outputs must stay quiet here.

		fd = $fopen("dv/conv_golden.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open the golden file dv/conv_golden.txt");
			$display(">>> FAIL");
			$finish;
		end
		else
		begin
			pixels_sent   = 0;
			frame_pending = 1'b0;
			code = $fscanf(fd, " %c", tag);
			while (code == 1)
			begin
				if ((tag == "W" || tag == "P") && frame_pending)
				begin
					wait_frame_done();
					frame_pending = 1'b0;
				end
				case (tag)
					"W":
						for (int k = 0; k < `CONV_KERNEL; k++)
						begin
							code = $fscanf(fd, " %h", word);
							send_weight(word);
						end
					"P":
						for (int k = 0; k < `CONV_IMG_WIDTH; k++)
						begin
							code = $fscanf(fd, " %h", word);
							send_pixel(word);
							pixels_sent++;
						end
					"X":
						for (int k = 0; k < STRAY_COUNT; k++)
						begin
							code = $fscanf(fd, " %h", word);
							send_pixel(word);
						end
					default:
						code = $fgets(rest, fd); // comments and expected values.
				endcase
				if (pixels_sent == FRAME_PIX)
				begin
					pixels_sent   = 0;
					frame_pending = 1'b1;
				end
				code = $fscanf(fd, " %c", tag);
			end
			$fclose(fd);
			if (frame_pending)
				wait_frame_done();
			repeat (3) step();
			run_over = 1'b1;
			repeat (2) step();
			$display("errors: %0d value mismatches, %0d sequence faults",
				mismatch_errors, protocol_errors);
			if (mismatch_errors == 0 && protocol_errors == 0)
				$display(">>> PASS");
			else
				$display(">>> FAIL");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* logic/conv_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module conv_ctrl (
	input  logic          clk,
	input  logic          reset,
	input  logic          weight_valid,
	input  logic          pixel_valid,
	count_if.ctrl         cnt,
	output logic          weights_ready,
	output logic          frame_done
);

	conv_pkg::conv_state_t state;
	conv_pkg::conv_state_t state_next;
	logic                  weight_take;
	logic                  pixel_take;

	// a weight wins over a pixel offered in the same cycle.
	assign weight_take = weight_valid && (state == conv_pkg::IDLE ||
		state == conv_pkg::LOAD || state == conv_pkg::READY);
	assign pixel_take = pixel_valid && !weight_take &&
		(state == conv_pkg::READY || state == conv_pkg::STREAM);

	//----------------------------------------------------------------------
	// next state
	//----------------------------------------------------------------------
	always_comb
	begin
		state_next = state;
		case (state)
			conv_pkg::IDLE:
				if (weight_take)
					state_next = conv_pkg::LOAD;
			conv_pkg::LOAD:
				if (weight_take && cnt.weight_last)
					state_next = conv_pkg::READY;
			conv_pkg::READY:
				if (weight_take)
					state_next = conv_pkg::LOAD; // reload.
				else if (pixel_take)
					state_next = cnt.frame_last ? conv_pkg::DRAIN : conv_pkg::STREAM;
			conv_pkg::STREAM:
				if (pixel_take && cnt.frame_last)
					state_next = conv_pkg::DRAIN;
			conv_pkg::DRAIN:
				if (cnt.drain_done)
					state_next = conv_pkg::READY;
			default:
				state_next = conv_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state      <= conv_pkg::IDLE;
			frame_done <= 1'b0;
		end
		else
		begin
			state      <= state_next;
			frame_done <= (state == conv_pkg::DRAIN) && cnt.drain_done; // one-cycle pulse.
		end
	end

	assign cnt.weight_step  = weight_take;
	assign cnt.weight_clear = weight_take && (state == conv_pkg::IDLE || state == conv_pkg::READY);
	assign cnt.pixel_accept = pixel_take;
	assign cnt.drain_start  = pixel_take && cnt.frame_last;
	// restart the raster position on a new load and after each drain.
	assign cnt.frame_clear  = cnt.weight_clear || ((state == conv_pkg::DRAIN) && cnt.drain_done);

	assign weights_ready = (state == conv_pkg::READY) || (state == conv_pkg::STREAM) ||
		(state == conv_pkg::DRAIN);

endmodule

`default_nettype wire

/* logic/conv_defs.svh */
`ifndef CONV_DEFS_SVH
`define CONV_DEFS_SVH

// arithmetic width for pixels, weights and results.
`define CONV_DATA_WIDTH 16

// kernel geometry.
`define CONV_KERNEL 5
`define CONV_TAPS 25

// frame geometry.
`define CONV_IMG_WIDTH 8
`define CONV_IMG_HEIGHT 6

// edges from pixel accept to conv_valid.
`define CONV_LATENCY 6

`endif

/* logic/conv_pkg.sv */
`default_nettype none

`include "conv_defs.svh"

package conv_pkg;

	// one signed word, used for pixels, weights and results.
	typedef logic signed [`CONV_DATA_WIDTH - 1:0] pixel_t;

	// entry 0 is the top-left tap, raster order from there.
	typedef pixel_t [`CONV_TAPS - 1:0] window_t;

	typedef enum logic [2:0]
	{
		IDLE,
		LOAD,
		READY,
		STREAM,
		DRAIN
	} conv_state_t;

endpackage

`default_nettype wire

/* logic/conv_top.sv */
`timescale 1ns/1ns
`default_nettype none

module conv_top (
	input  logic             clk,
	input  logic             reset,
	input  logic             weight_valid,
	input  conv_pkg::pixel_t weight_data,
	input  logic             pixel_valid,
	input  conv_pkg::pixel_t pixel_data,
	output logic             conv_valid,
	output conv_pkg::pixel_t conv_data,
	output logic             weights_ready,
	output logic             frame_done
);

	conv_pkg::window_t weights;
	conv_pkg::window_t window;
	logic              window_valid;

	count_if cnt ();

	//----------------------------------------------------------------------
	// control
	//----------------------------------------------------------------------
	conv_ctrl u_ctrl (
		.clk           (clk),
		.reset         (reset),
		.weight_valid  (weight_valid),
		.pixel_valid   (pixel_valid),
		.cnt           (cnt),
		.weights_ready (weights_ready),
		.frame_done    (frame_done)
	);

	frame_counter u_counter (
		.clk   (clk),
		.reset (reset),
		.cnt   (cnt)
	);

	//----------------------------------------------------------------------
	// datapath
	//----------------------------------------------------------------------
	weight_bank u_weights (
		.clk         (clk),
		.reset       (reset),
		.weight_step (cnt.weight_step),
		.weight_data (weight_data),
		.weights     (weights)
	);

	line_window u_window (
		.clk          (clk),
		.reset        (reset),
		.pixel_data   (pixel_data),
		.cnt          (cnt),
		.window       (window),
		.window_valid (window_valid)
	);

	conv_tree u_tree (
		.clk         (clk),
		.reset       (reset),
		.conv_enable (window_valid), // products load once per full window.
		.weights     (weights),
		.window      (window),
		.conv_valid  (conv_valid),
		.conv_data   (conv_data)
	);

endmodule

`default_nettype wire

/* logic/conv_tree.sv */
`timescale 1ns/1ns
`default_nettype none

`include "conv_defs.svh"

module conv_tree (
	input  logic              clk,
	input  logic              reset,
	input  logic              conv_enable,
	input  conv_pkg::window_t weights,
	input  conv_pkg::window_t window,
	output logic              conv_valid,
	output conv_pkg::pixel_t  conv_data
);

	conv_pkg::window_t       prod;
	conv_pkg::pixel_t [12:0] sum1;
	conv_pkg::pixel_t [6:0]  sum2;
	conv_pkg::pixel_t [3:0]  sum3;
	conv_pkg::pixel_t [1:0]  sum4;
	conv_pkg::pixel_t        sum5;

	logic [`CONV_LATENCY - 1:0] valid_pipe;

	//----------------------------------------------------------------------
	// multipliers
	//----------------------------------------------------------------------
	// only the low word of each product is kept.
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			prod <= '0;
		else if (conv_enable)
		begin
			for (int k = 0; k < `CONV_TAPS; k++)
			begin
				prod[k] <= weights[k] * window[k];
			end
		end
	end

	//----------------------------------------------------------------------
	// adder tree
	//----------------------------------------------------------------------
	// free running, odd lane passes straight on at each level.
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			sum1 <= '0;
			sum2 <= '0;
			sum3 <= '0;
			sum4 <= '0;
			sum5 <= '0;
		end
		else
		begin
			for (int i = 0; i < 12; i++)
			begin
				sum1[i] <= prod[2 * i] + prod[2 * i + 1];
			end
			sum1[12] <= prod[24];
			for (int i = 0; i < 6; i++)
			begin
				sum2[i] <= sum1[2 * i] + sum1[2 * i + 1];
			end
			sum2[6] <= sum1[12];
			for (int i = 0; i < 3; i++)
			begin
				sum3[i] <= sum2[2 * i] + sum2[2 * i + 1];
			end
			sum3[3] <= sum2[6];
			sum4[0] <= sum3[0] + sum3[1];
			sum4[1] <= sum3[2] + sum3[3];
			sum5    <= sum4[0] + sum4[1];
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			valid_pipe <= '0;
		else
			valid_pipe <= {valid_pipe[`CONV_LATENCY - 2:0], conv_enable};
	end

	assign conv_valid = valid_pipe[`CONV_LATENCY - 1];
	assign conv_data  = sum5;

endmodule

`default_nettype wire

/* logic/count_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface count_if;

	// strobes from the controller.
	logic weight_clear;
	logic weight_step;
	logic pixel_accept;
	logic frame_clear;
	logic drain_start;

	// status from the counters.
	logic weight_last;
	logic frame_last;
	logic window_hit;
	logic drain_done;

	modport ctrl (
		output weight_clear, weight_step, pixel_accept, frame_clear, drain_start,
		input  weight_last, frame_last, drain_done
	);

	modport counter (
		input  weight_clear, weight_step, pixel_accept, frame_clear, drain_start,
		output weight_last, frame_last, window_hit, drain_done
	);

	modport window (
		input pixel_accept, window_hit
	);

endinterface

`default_nettype wire

/* logic/frame_counter.sv */
`timescale 1ns/1ns
`default_nettype none

`include "conv_defs.svh"

module frame_counter (
	input  logic     clk,
	input  logic     reset,
	count_if.counter cnt
);

	logic [4:0] weight_idx;
	logic [2:0] col;
	logic [2:0] row;
	logic [2:0] drain_cnt;

	// the first weight of a load clears and counts in one step.
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			weight_idx <= 5'd0;
		else if (cnt.weight_step)
			weight_idx <= cnt.weight_clear ? 5'd1 : weight_idx + 5'd1;
	end

	//----------------------------------------------------------------------
	// raster position
	//----------------------------------------------------------------------
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			col <= 3'd0;
			row <= 3'd0;
		end
		else if (cnt.frame_clear)
		begin
			col <= 3'd0;
			row <= 3'd0;
		end
		else if (cnt.pixel_accept)
		begin
			if (col == 3'(`CONV_IMG_WIDTH - 1))
			begin
				col <= 3'd0;
				row <= (row == 3'(`CONV_IMG_HEIGHT - 1)) ? 3'd0 : row + 3'd1;
			end
			else
				col <= col + 3'd1;
		end
	end

	// counts down over the tree latency plus one.
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			drain_cnt <= 3'd0;
		else if (cnt.drain_start)
			drain_cnt <= 3'(`CONV_LATENCY + 1);
		else if (drain_cnt != 3'd0)
			drain_cnt <= drain_cnt - 3'd1;
	end

	assign cnt.weight_last = (weight_idx == 5'(`CONV_TAPS - 1));
	assign cnt.frame_last  = (col == 3'(`CONV_IMG_WIDTH - 1)) && (row == 3'(`CONV_IMG_HEIGHT - 1));
	assign cnt.window_hit  = (col >= 3'(`CONV_KERNEL - 1)) && (row >= 3'(`CONV_KERNEL - 1));
	assign cnt.drain_done  = (drain_cnt == 3'd1);

endmodule

`default_nettype wire

/* logic/line_window.sv */
`timescale 1ns/1ns
`default_nettype none

`include "conv_defs.svh"

module line_window (
	input  logic              clk,
	input  logic              reset,
	input  conv_pkg::pixel_t  pixel_data,
	count_if.window           cnt,
	output conv_pkg::window_t window,
	output logic              window_valid
);

	localparam int LINE_LEN = (`CONV_KERNEL - 1) * `CONV_IMG_WIDTH;

	// entry 0 is the most recent pixel.
	conv_pkg::pixel_t [LINE_LEN - 1:0]     line_buf;
	conv_pkg::pixel_t [`CONV_KERNEL - 1:0] row_in;

	//----------------------------------------------------------------------
	// line delay
	//----------------------------------------------------------------------
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			line_buf <= '0;
		else if (cnt.pixel_accept)
			line_buf <= {line_buf[LINE_LEN - 2:0], pixel_data};
	end

	// each window row takes the pixel one more frame line back.
	always_comb
	begin
		for (int r = 0; r < `CONV_KERNEL - 1; r++)
		begin
			row_in[r] = line_buf[(`CONV_KERNEL - 1 - r) * `CONV_IMG_WIDTH - 1];
		end
		row_in[`CONV_KERNEL - 1] = pixel_data; // bottom row is the live pixel.
	end

	//----------------------------------------------------------------------
	// window register
	//----------------------------------------------------------------------
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			window <= '0;
		else if (cnt.pixel_accept)
		begin
			for (int r = 0; r < `CONV_KERNEL; r++)
			begin
				for (int c = 0; c < `CONV_KERNEL - 1; c++)
				begin
					window[r * `CONV_KERNEL + c] <= window[r * `CONV_KERNEL + c + 1];
				end
				window[r * `CONV_KERNEL + `CONV_KERNEL - 1] <= row_in[r];
			end
		end
	end

	// the window is complete only once column and row reach the kernel edge.
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			window_valid <= 1'b0;
		else
			window_valid <= cnt.pixel_accept && cnt.window_hit;
	end

endmodule

`default_nettype wire

/* logic/weight_bank.sv */
`timescale 1ns/1ns
`default_nettype none

`include "conv_defs.svh"

module weight_bank (
	input  logic              clk,
	input  logic              reset,
	input  logic              weight_step,
	input  conv_pkg::pixel_t  weight_data,
	output conv_pkg::window_t weights
);

	// new weights enter at the top entry and move down one per step,
	// so after a full load the first weight sits in entry 0.
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			weights <= '0;
		else if (weight_step)
		begin
			for (int k = 0; k < `CONV_TAPS - 1; k++)
			begin
				weights[k] <= weights[k + 1];
			end
			weights[`CONV_TAPS - 1] <= weight_data;
		end
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# builds the convolution engine testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ns --top-module conv_tb -f conv_engine.f \
	-o conv_sim || { echo "verilator build failed"; exit 1; }
./obj_dir/conv_sim | tee sim.log
grep -qx '>>> PASS' sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
